//--- Makefile
# Verilator lint and simulation of the pipeline controller

VERILATOR ?= verilator
FLAGS     := --timing
TOP       := tb_ctrl_top
RTL_TOP   := ctrl_top
FILELIST  := ctrl_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- ctrl_checker.sv
// testbench checker, compares the controller outputs with the expected values of each cycle
`timescale 1ns/1ps

module ctrl_checker
(
  input  logic               clk,
  input  logic               check_en_i,

  // observed DUT outputs
  input  logic               busy_i,
  input  logic               decoding_i,
  input  logic               req_i,
  input  logic               pc_set_i,
  input  ctrl_pkg::pc_sel_e  pc_mux_i,
  input  logic               halt_if_i,
  input  logic               halt_id_i,
  input  logic               deassert_we_i,
  input  logic               load_stall_i,
  input  logic               jr_stall_i,
  input  ctrl_pkg::fw_sel_e  fw_a_i,
  input  ctrl_pkg::fw_sel_e  fw_b_i,
  input  ctrl_pkg::fw_sel_e  fw_c_i,

  // expected values from the stimulus file
  input  logic               exp_busy_i,
  input  logic               exp_decoding_i,
  input  logic               exp_req_i,
  input  logic               exp_pc_set_i,
  input  logic [2:0]         exp_pc_mux_i,
  input  logic               exp_halt_if_i,
  input  logic               exp_halt_id_i,
  input  logic               exp_deassert_we_i,
  input  logic               exp_load_stall_i,
  input  logic               exp_jr_stall_i,
  input  logic [1:0]         exp_fw_a_i,
  input  logic [1:0]         exp_fw_b_i,
  input  logic [1:0]         exp_fw_c_i,

  output int                 errors_o,
  output int                 checks_o
);

  int err_count   = 0;
  int check_count = 0;

  assign errors_o = err_count;
  assign checks_o = check_count;

  // one output against its expected value, widened to 3 bits
  task automatic compare_field(input string name, input logic [2:0] got,
                               input logic [2:0] exp);
    if (got !== exp)
    begin
      err_count = err_count + 1;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // sampling
  //////////////////////////////////////////////////////////////////////

  // outputs settle after the falling edge drive, read them before the state moves
  always @(posedge clk)
  begin
    if (check_en_i)
    begin
      check_count = check_count + 1;
      compare_field("core_busy_o", {2'b00, busy_i}, {2'b00, exp_busy_i});
      compare_field("is_decoding_o", {2'b00, decoding_i}, {2'b00, exp_decoding_i});
      compare_field("instr_req_o", {2'b00, req_i}, {2'b00, exp_req_i});
      compare_field("pc_set_o", {2'b00, pc_set_i}, {2'b00, exp_pc_set_i});
      compare_field("pc_mux_o", pc_mux_i, exp_pc_mux_i);
      compare_field("halt_if_o", {2'b00, halt_if_i}, {2'b00, exp_halt_if_i});
      compare_field("halt_id_o", {2'b00, halt_id_i}, {2'b00, exp_halt_id_i});
      compare_field("deassert_we_o", {2'b00, deassert_we_i}, {2'b00, exp_deassert_we_i});
      compare_field("load_stall_o", {2'b00, load_stall_i}, {2'b00, exp_load_stall_i});
      compare_field("jr_stall_o", {2'b00, jr_stall_i}, {2'b00, exp_jr_stall_i});
      // forwarding selects
      compare_field("operand_a_fw_sel_o", {1'b0, fw_a_i}, {1'b0, exp_fw_a_i});
      compare_field("operand_b_fw_sel_o", {1'b0, fw_b_i}, {1'b0, exp_fw_b_i});
      compare_field("operand_c_fw_sel_o", {1'b0, fw_c_i}, {1'b0, exp_fw_c_i});
    end
  end

endmodule

//--- ctrl_consts.svh
// sizing constants for the pipeline controller, included by the package and the RTL
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// register file geometry
//////////////////////////////////////////////////////////////////////

// width of a register address in the decoder and forwarding paths
`define CTRL_REG_ADDR_W 5

// architectural register count, x0 through x31
`define CTRL_NUM_REGS (1 << `CTRL_REG_ADDR_W)

//////////////////////////////////////////////////////////////////////
// operand geometry
//////////////////////////////////////////////////////////////////////

// source operands a, b and c, bit 0 is operand a
`define CTRL_NUM_OPERANDS 3

`endif

//--- ctrl_fsm.sv
// main control FSM of the core, drives fetch requests, pc redirects and pipeline halts
`timescale 1ns/1ps

module ctrl_fsm
(
  input  logic                   clk,
  input  logic                   rst_n,

  // core enable and decoder status
  input  logic                   fetch_enable_i,
  input  logic                   instr_valid_i,
  input  logic                   pipe_flush_i,
  input  logic                   branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e   jump_in_dec_i,
  input  logic                   jr_stall_i,

  // stage handshakes
  input  logic                   id_valid_i,
  input  logic                   ex_valid_i,
  input  logic                   wb_valid_i,

  output logic                   core_busy_o,
  output logic                   is_decoding_o,
  output logic                   instr_req_o,
  output logic                   pc_set_o,
  output ctrl_pkg::pc_sel_e      pc_mux_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  // set once a jump target was sent, blocks a second redirect
  logic jump_done_d;
  logic jump_done_q;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // fetching and busy unless idle
    instr_req_o   = 1'b1;
    core_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_mux_o      = ctrl_pkg::PC_BOOT;
    pc_set_o      = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    jump_done_d   = jump_done_q;
    state_d       = state_q;

    case (state_q)
      // idle after reset until enabled
      ctrl_pkg::RESET:
      begin
        instr_req_o = 1'b0;
        core_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = ctrl_pkg::BOOT_SET;
      end

      // load the boot address into the prefetcher
      ctrl_pkg::BOOT_SET:
      begin
        pc_mux_o = ctrl_pkg::PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // pipeline drained, wait for the core to be enabled again
      ctrl_pkg::SLEEP:
      begin
        instr_req_o = 1'b0;
        core_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = ctrl_pkg::FIRST_FETCH;
      end

      // wait for the first instruction to leave ID
      ctrl_pkg::FIRST_FETCH:
      begin
        if (id_valid_i)
          state_d = ctrl_pkg::DECODE;
      end

      ctrl_pkg::DECODE:
      begin
        // decode only while no taken branch sits in EX
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          // jal and jalr targets are known in decode
          if ((jump_in_dec_i == ctrl_pkg::BRANCH_JAL) ||
              (jump_in_dec_i == ctrl_pkg::BRANCH_JALR))
          begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // jalr waits for its base register, one redirect per jump
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi style flush, stop IF and ID right away
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end

        // taken branch wins over anything in decode
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = ctrl_pkg::PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
        end
      end

      // let the instruction in EX complete
      ctrl_pkg::FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        if (ex_valid_i)
          state_d = ctrl_pkg::FLUSH_WB;
      end

      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        if (!fetch_enable_i)
        begin
          // going to sleep once WB retires
          if (wb_valid_i)
            state_d = ctrl_pkg::SLEEP;
        end
        else
        begin
          // still enabled, release IF and resume
          halt_if_o = 1'b0;
          if (id_valid_i)
            state_d = ctrl_pkg::DECODE;
        end
      end

      // unreachable encoding, recover through reset state
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and jump-done registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // ID handing on the jump ends the blocking window
      jump_done_q <= jump_done_d & ~id_valid_i;
    end
  end

endmodule

//--- ctrl_pkg.sv
// shared types of the pipeline controller, referenced by scoped names from every RTL unit
`include "ctrl_consts.svh"

package ctrl_pkg;

  // register address, sized from the register count
  typedef logic [$clog2(`CTRL_NUM_REGS)-1:0] reg_addr_t;

  // controller FSM states
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // fetch stage pc select
  // 3'b001 and 3'b100 upward stay reserved for exception, eret and debug
  typedef enum logic [2:0] {
    PC_BOOT   = 3'b000,
    PC_JUMP   = 3'b010,
    PC_BRANCH = 3'b011
  } pc_sel_e;

  // kind of jump sitting in decode
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand source in the ID stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

endpackage

//--- ctrl_top.f
+incdir+.
ctrl_pkg.sv
ctrl_fsm.sv
operand_match.sv
hazard_unit.sv
fwd_unit.sv
ctrl_top.sv
ctrl_checker.sv
tb_ctrl_top.sv

//--- ctrl_top.sv
// top level of the pipeline controller, connects FSM, operand matching, hazards and forwarding
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module ctrl_top
(
  input  logic                   clk,
  input  logic                   rst_n,

  // control
  input  logic                   fetch_enable_i,
  input  logic                   instr_valid_i,
  input  logic                   pipe_flush_i,
  input  logic                   illegal_insn_i,
  input  logic                   branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e   jump_in_dec_i,

  // stage handshakes
  input  logic                   id_valid_i,
  input  logic                   ex_valid_i,
  input  logic                   wb_valid_i,

  // LSU
  input  logic                   data_req_ex_i,
  input  logic                   data_misaligned_i,

  // source operands
  input  logic                   rega_used_i,
  input  logic                   regb_used_i,
  input  logic                   regc_used_i,
  input  ctrl_pkg::reg_addr_t    raddr_a_i,
  input  ctrl_pkg::reg_addr_t    raddr_b_i,
  input  ctrl_pkg::reg_addr_t    raddr_c_i,

  // destinations
  input  ctrl_pkg::reg_addr_t    regfile_waddr_ex_i,
  input  logic                   regfile_we_ex_i,
  input  ctrl_pkg::reg_addr_t    regfile_waddr_wb_i,
  input  logic                   regfile_we_wb_i,
  input  ctrl_pkg::reg_addr_t    regfile_alu_waddr_fw_i,
  input  logic                   regfile_alu_we_fw_i,

  output logic                   core_busy_o,
  output logic                   is_decoding_o,
  output logic                   instr_req_o,
  output logic                   pc_set_o,
  output ctrl_pkg::pc_sel_e      pc_mux_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o,
  output logic                   deassert_we_o,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output ctrl_pkg::fw_sel_e      operand_a_fw_sel_o,
  output ctrl_pkg::fw_sel_e      operand_b_fw_sel_o,
  output ctrl_pkg::fw_sel_e      operand_c_fw_sel_o
);

  // per operand address matches, bit 0 is operand a
  logic [`CTRL_NUM_OPERANDS-1:0] ex_match;
  logic [`CTRL_NUM_OPERANDS-1:0] wb_match;
  logic [`CTRL_NUM_OPERANDS-1:0] alu_match;

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .pipe_flush_i      (pipe_flush_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .jr_stall_i        (jr_stall_o),
    .id_valid_i        (id_valid_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .core_busy_o       (core_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  operand_match u_operand_match (
    .rega_used_i (rega_used_i),
    .regb_used_i (regb_used_i),
    .regc_used_i (regc_used_i),
    .raddr_a_i   (raddr_a_i),
    .raddr_b_i   (raddr_b_i),
    .raddr_c_i   (raddr_c_i),
    .waddr_ex_i  (regfile_waddr_ex_i),
    .waddr_wb_i  (regfile_waddr_wb_i),
    .waddr_alu_i (regfile_alu_waddr_fw_i),
    .ex_match_o  (ex_match),
    .wb_match_o  (wb_match),
    .alu_match_o (alu_match)
  );

  hazard_unit u_hazard_unit (
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .data_req_ex_i  (data_req_ex_i),
    .we_ex_i        (regfile_we_ex_i),
    .we_wb_i        (regfile_we_wb_i),
    .we_alu_i       (regfile_alu_we_fw_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .ex_match_i     (ex_match),
    .wb_match_i     (wb_match),
    .alu_match_i    (alu_match),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  fwd_unit u_fwd_unit (
    .we_wb_i            (regfile_we_wb_i),
    .we_alu_i           (regfile_alu_we_fw_i),
    .data_misaligned_i  (data_misaligned_i),
    .wb_match_i         (wb_match),
    .alu_match_i        (alu_match),
    .operand_a_fw_sel_o (operand_a_fw_sel_o),
    .operand_b_fw_sel_o (operand_b_fw_sel_o),
    .operand_c_fw_sel_o (operand_c_fw_sel_o)
  );

endmodule

//--- ctrl_top_input.txt
// in: ctl(fetch_en valid flush illegal branch) jump vld(id ex wb) mem(req misal) used(abc)
//     raddr_a raddr_b raddr_c waddr_ex we_ex waddr_wb we_wb waddr_alu we_alu
// out: stat(busy dec req pcset) pc_mux halt(if id) stall(deassert load jr) fw_a fw_b fw_c
00000 0 000 00 000 00 00 00 00 0 00 0 00 0  0000 0 00 100 0 0 0
10000 0 000 00 000 00 00 00 00 0 00 0 00 0  0000 0 00 100 0 0 0
10000 0 000 00 000 00 00 00 00 0 00 0 00 0  1011 0 00 100 0 0 0
10000 0 000 00 000 00 00 00 00 0 00 0 00 0  1010 0 00 100 0 0 0
10000 0 100 00 000 00 00 00 00 0 00 0 00 0  1010 0 00 100 0 0 0
11000 0 100 00 110 05 00 05 00 0 05 1 05 1  1110 0 00 000 1 0 0
11000 0 100 00 111 03 00 03 00 0 03 1 00 1  1110 0 00 000 2 0 2
11000 0 100 01 111 02 02 02 00 0 02 1 00 0  1110 0 00 000 1 0 2
11000 0 100 10 100 08 00 00 08 1 00 0 00 0  1110 0 00 110 0 0 0
11000 2 000 00 100 09 00 00 00 0 00 0 09 1  1110 2 00 101 1 0 0
11000 2 000 00 100 09 00 00 00 0 00 0 09 0  1111 2 00 000 0 0 0
11000 2 100 00 100 09 00 00 00 0 00 0 09 0  1110 2 00 000 0 0 0
11010 0 100 00 000 00 00 00 00 0 00 0 00 0  1110 0 00 100 0 0 0
11000 1 000 00 000 00 00 00 00 0 00 0 00 0  1111 2 00 000 0 0 0
11000 1 000 00 000 00 00 00 00 0 00 0 00 0  1110 2 00 000 0 0 0
11000 1 100 00 000 00 00 00 00 0 00 0 00 0  1110 2 00 000 0 0 0
11001 1 000 00 000 00 00 00 00 0 00 0 00 0  1011 3 00 100 0 0 0
11100 0 000 00 000 00 00 00 00 0 00 0 00 0  1110 0 11 000 0 0 0
00000 0 000 00 000 00 00 00 00 0 00 0 00 0  1010 0 10 100 0 0 0
00000 0 010 00 000 00 00 00 00 0 00 0 00 0  1010 0 10 100 0 0 0
00000 0 000 00 000 00 00 00 00 0 00 0 00 0  1010 0 10 100 0 0 0
00000 0 001 00 000 00 00 00 00 0 00 0 00 0  1010 0 10 100 0 0 0
00000 0 000 00 000 00 00 00 00 0 00 0 00 0  0000 0 00 100 0 0 0
10000 0 000 00 000 00 00 00 00 0 00 0 00 0  0000 0 00 100 0 0 0
10000 0 100 00 000 00 00 00 00 0 00 0 00 0  1010 0 00 100 0 0 0
11000 0 100 00 000 00 00 00 00 0 00 0 00 0  1110 0 00 000 0 0 0

//--- fwd_unit.sv
// picks the source of each ID stage operand from regfile, WB result or EX result
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module fwd_unit
(
  input  logic                            we_wb_i,
  input  logic                            we_alu_i,
  input  logic                            data_misaligned_i,

  // address matches, bit 0 is operand a
  input  logic [`CTRL_NUM_OPERANDS-1:0]   wb_match_i,
  input  logic [`CTRL_NUM_OPERANDS-1:0]   alu_match_i,

  output ctrl_pkg::fw_sel_e               operand_a_fw_sel_o,
  output ctrl_pkg::fw_sel_e               operand_b_fw_sel_o,
  output ctrl_pkg::fw_sel_e               operand_c_fw_sel_o
);

  ctrl_pkg::fw_sel_e fw_sel [`CTRL_NUM_OPERANDS];

  always_comb
  begin
    for (int i = 0; i < `CTRL_NUM_OPERANDS; i++)
    begin
      // register file unless a newer value is in flight
      fw_sel[i] = ctrl_pkg::SEL_REGFILE;
      // older result from WB
      if (we_wb_i && wb_match_i[i])
        fw_sel[i] = ctrl_pkg::SEL_FW_WB;
      // youngest result from EX takes priority
      if (we_alu_i && alu_match_i[i])
        fw_sel[i] = ctrl_pkg::SEL_FW_EX;
    end

    // second half of a misaligned access reuses the EX address
    if (data_misaligned_i)
    begin
      fw_sel[0] = ctrl_pkg::SEL_FW_EX;
      fw_sel[1] = ctrl_pkg::SEL_REGFILE;
    end
  end

  assign operand_a_fw_sel_o = fw_sel[0];
  assign operand_b_fw_sel_o = fw_sel[1];
  assign operand_c_fw_sel_o = fw_sel[2];

endmodule

//--- hazard_unit.sv
// detects load-use and jump-register hazards and decides when to drop register writes
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module hazard_unit
(
  input  logic                            is_decoding_i,
  input  logic                            illegal_insn_i,
  input  logic                            data_req_ex_i,

  // destination write enables
  input  logic                            we_ex_i,
  input  logic                            we_wb_i,
  input  logic                            we_alu_i,

  input  ctrl_pkg::jump_kind_e            jump_in_dec_i,

  // address matches, bit 0 is operand a
  input  logic [`CTRL_NUM_OPERANDS-1:0]   ex_match_i,
  input  logic [`CTRL_NUM_OPERANDS-1:0]   wb_match_i,
  input  logic [`CTRL_NUM_OPERANDS-1:0]   alu_match_i,

  output logic                            load_stall_o,
  output logic                            jr_stall_o,
  output logic                            deassert_we_o
);

  logic jalr_in_dec;
  logic jalr_base_busy;

  //////////////////////////////////////////////////////////////////////
  // load-use hazard
  //////////////////////////////////////////////////////////////////////

  // load in EX writes a register that ID reads
  assign load_stall_o = data_req_ex_i && we_ex_i && (|ex_match_i);

  //////////////////////////////////////////////////////////////////////
  // jump-register hazard
  //////////////////////////////////////////////////////////////////////

  assign jalr_in_dec = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);

  // jalr base is operand a, any pending writer of it stalls
  assign jalr_base_busy = (we_wb_i  && wb_match_i[0])  ||
                          (we_ex_i  && ex_match_i[0])  ||
                          (we_alu_i && alu_match_i[0]);

  assign jr_stall_o = jalr_in_dec && jalr_base_busy;

  //////////////////////////////////////////////////////////////////////
  // write enable suppression
  //////////////////////////////////////////////////////////////////////

  // no writes from an instruction that is not really issued
  assign deassert_we_o = !is_decoding_i  ||
                         illegal_insn_i  ||
                         load_stall_o    ||
                         jr_stall_o;

endmodule

//--- operand_match.sv
// compares the three source register addresses with the EX, WB and ALU destinations
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module operand_match
(
  input  logic                                rega_used_i,
  input  logic                                regb_used_i,
  input  logic                                regc_used_i,
  input  ctrl_pkg::reg_addr_t                 raddr_a_i,
  input  ctrl_pkg::reg_addr_t                 raddr_b_i,
  input  ctrl_pkg::reg_addr_t                 raddr_c_i,
  input  ctrl_pkg::reg_addr_t                 waddr_ex_i,
  input  ctrl_pkg::reg_addr_t                 waddr_wb_i,
  input  ctrl_pkg::reg_addr_t                 waddr_alu_i,

  // one bit per operand, bit 0 is operand a
  output logic [`CTRL_NUM_OPERANDS-1:0]       ex_match_o,
  output logic [`CTRL_NUM_OPERANDS-1:0]       wb_match_o,
  output logic [`CTRL_NUM_OPERANDS-1:0]       alu_match_o
);

  ctrl_pkg::reg_addr_t            raddr [`CTRL_NUM_OPERANDS];
  logic [`CTRL_NUM_OPERANDS-1:0]  used;

  // gather operands into indexable form
  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;
  assign raddr[2] = raddr_c_i;
  assign used     = {regc_used_i, regb_used_i, rega_used_i};

  for (genvar i = 0; i < `CTRL_NUM_OPERANDS; i++)
  begin : g_match
    // source is read and is not x0
    logic live;

    assign live = used[i] && (raddr[i] != '0);

    // write enables are applied downstream
    assign ex_match_o[i]  = live && (raddr[i] == waddr_ex_i);
    assign wb_match_o[i]  = live && (raddr[i] == waddr_wb_i);
    assign alu_match_o[i] = live && (raddr[i] == waddr_alu_i);
  end

endmodule

//--- tb_ctrl_top.sv
// testbench top for the pipeline controller, replays per-cycle vectors from the input file
`timescale 1ns/1ps

module tb_ctrl_top;

  localparam int RESET_CYCLES = 3;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic fetch_enable, instr_valid, pipe_flush, illegal_insn, branch_taken;
  ctrl_pkg::jump_kind_e jump_in_dec;
  logic id_valid, ex_valid, wb_valid, data_req_ex, data_misaligned;
  logic rega_used, regb_used, regc_used;
  ctrl_pkg::reg_addr_t raddr_a, raddr_b, raddr_c;
  ctrl_pkg::reg_addr_t waddr_ex, waddr_wb, waddr_alu;
  logic we_ex, we_wb, we_alu;

  // DUT outputs
  logic core_busy, is_decoding, instr_req, pc_set;
  ctrl_pkg::pc_sel_e pc_mux;
  logic halt_if, halt_id, deassert_we, load_stall, jr_stall;
  ctrl_pkg::fw_sel_e fw_a, fw_b, fw_c;

  // expected groups as laid out in the file
  logic [3:0] exp_stat;
  logic [2:0] exp_pc;
  logic [1:0] exp_halt;
  logic [2:0] exp_stall;
  logic [1:0] exp_fw_a, exp_fw_b, exp_fw_c;

  logic  check_en;
  bit    file_ok;
  string line_q[$];
  int    bad_lines   = 0;
  int    cycle_count = 0;
  int    cycle_limit;
  int    errors;
  int    checks;

  always #50 clk = ~clk;

  ctrl_top UUT (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .instr_valid_i (instr_valid),
    .pipe_flush_i (pipe_flush), .illegal_insn_i (illegal_insn),
    .branch_taken_ex_i (branch_taken), .jump_in_dec_i (jump_in_dec),
    .id_valid_i (id_valid), .ex_valid_i (ex_valid), .wb_valid_i (wb_valid),
    .data_req_ex_i (data_req_ex), .data_misaligned_i (data_misaligned),
    .rega_used_i (rega_used), .regb_used_i (regb_used), .regc_used_i (regc_used),
    .raddr_a_i (raddr_a), .raddr_b_i (raddr_b), .raddr_c_i (raddr_c),
    .regfile_waddr_ex_i (waddr_ex), .regfile_we_ex_i (we_ex),
    .regfile_waddr_wb_i (waddr_wb), .regfile_we_wb_i (we_wb),
    .regfile_alu_waddr_fw_i (waddr_alu), .regfile_alu_we_fw_i (we_alu),
    .core_busy_o (core_busy), .is_decoding_o (is_decoding),
    .instr_req_o (instr_req), .pc_set_o (pc_set), .pc_mux_o (pc_mux),
    .halt_if_o (halt_if), .halt_id_o (halt_id), .deassert_we_o (deassert_we),
    .load_stall_o (load_stall), .jr_stall_o (jr_stall),
    .operand_a_fw_sel_o (fw_a), .operand_b_fw_sel_o (fw_b), .operand_c_fw_sel_o (fw_c)
  );

  ctrl_checker u_checker (
    .clk (clk), .check_en_i (check_en),
    .busy_i (core_busy), .decoding_i (is_decoding), .req_i (instr_req),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .halt_if_i (halt_if), .halt_id_i (halt_id),
    .deassert_we_i (deassert_we), .load_stall_i (load_stall), .jr_stall_i (jr_stall),
    .fw_a_i (fw_a), .fw_b_i (fw_b), .fw_c_i (fw_c),
    .exp_busy_i (exp_stat[3]), .exp_decoding_i (exp_stat[2]),
    .exp_req_i (exp_stat[1]), .exp_pc_set_i (exp_stat[0]), .exp_pc_mux_i (exp_pc),
    .exp_halt_if_i (exp_halt[1]), .exp_halt_id_i (exp_halt[0]),
    .exp_deassert_we_i (exp_stall[2]), .exp_load_stall_i (exp_stall[1]),
    .exp_jr_stall_i (exp_stall[0]),
    .exp_fw_a_i (exp_fw_a), .exp_fw_b_i (exp_fw_b), .exp_fw_c_i (exp_fw_c),
    .errors_o (errors), .checks_o (checks)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic clear_inputs();
    {fetch_enable, instr_valid, pipe_flush, illegal_insn, branch_taken} = '0;
    jump_in_dec = ctrl_pkg::BRANCH_NONE;
    {id_valid, ex_valid, wb_valid, data_req_ex, data_misaligned} = '0;
    {rega_used, regb_used, regc_used} = '0;
    {raddr_a, raddr_b, raddr_c, waddr_ex, waddr_wb, waddr_alu} = '0;
    {we_ex, we_wb, we_alu} = '0;
    {exp_stat, exp_pc, exp_halt, exp_stall, exp_fw_a, exp_fw_b, exp_fw_c} = '0;
    check_en = 1'b0;
    rst_n    = 1'b0;
  endtask

  // keeps data lines only, comment and blank lines are dropped
  task automatic load_lines();
    int    fd;
    string line;
    fd      = $fopen("ctrl_top_input.txt", "r");
    file_ok = (fd != 0);
    if (file_ok)
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) != 0)
        begin
          if (line.len() > 2 && line.substr(0, 1) != "//")
            line_q.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // one cycle of inputs plus its expected outputs
  task automatic drive_line(input int idx, input string line);
    logic [4:0] ctl;
    logic [1:0] jmp;
    logic [2:0] vld;
    logic [1:0] mem;
    logic [2:0] used;
    int         n;
    n = $sscanf(line, "%b %h %b %b %b %h %h %h %h %h %h %h %h %h %b %h %b %b %h %h %h",
                ctl, jmp, vld, mem, used, raddr_a, raddr_b, raddr_c,
                waddr_ex, we_ex, waddr_wb, we_wb, waddr_alu, we_alu,
                exp_stat, exp_pc, exp_halt, exp_stall, exp_fw_a, exp_fw_b, exp_fw_c);
    if (n != 21)
    begin
      bad_lines = bad_lines + 1;
      $display("stimulus line %0d has %0d fields instead of 21", idx + 1, n);
    end
    {fetch_enable, instr_valid, pipe_flush, illegal_insn, branch_taken} = ctl;
    jump_in_dec = ctrl_pkg::jump_kind_e'(jmp);
    {id_valid, ex_valid, wb_valid} = vld;
    {data_req_ex, data_misaligned} = mem;
    {rega_used, regb_used, regc_used} = used;
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  // hang guard, file length plus reset plus slack
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("run stopped, no end after %0d clock cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial
  begin
    clear_inputs();
    load_lines();
    cycle_limit = line_q.size() + RESET_CYCLES + 20;
    if (!file_ok)
    begin
      $display("cannot open ctrl_top_input.txt, there is no stimulus to run");
      $display("TEST FAIL");
      $finish;
    end
    else
    begin
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n    = 1'b1;
      check_en = 1'b1;
      // new values on each falling edge, checked on the next rising edge
      foreach (line_q[i])
      begin
        drive_line(i, line_q[i]);
        @(negedge clk);
      end
      check_en = 1'b0;
      $display("checked %0d cycles, %0d mismatches, %0d bad stimulus lines",
               checks, errors, bad_lines);
      if (errors == 0 && bad_lines == 0 && checks == line_q.size() && checks > 0)
        $display("TEST PASS");
      else
        $display("TEST FAIL");
      $finish;
    end
  end

endmodule
